// ==== mc_bridge.f ====
+incdir+hw
hw/mc_bridge_pkg.sv
hw/cmd_fifo.sv
hw/request_issue.sv
hw/trans_slot.sv
hw/resp_collector.sv
hw/inbound_xlate.sv
hw/mc_bridge.sv
sim/mc_bridge_props.sv
sim/tb_mc_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the mc_bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f mc_bridge.f \
  --top-module tb_mc_bridge \
  --Mdir obj_dir -o sim_mc_bridge

./obj_dir/sim_mc_bridge

// ==== sim/tb_mc_bridge.sv ====
`include "mc_bridge_settings.svh"

`default_nettype none

module tb_mc_bridge;

  timeunit 1ns;
  timeprecision 1ps;

  import mc_bridge_pkg::*;

  localparam int WAIT_LIMIT = 50;
  localparam logic [`MCB_X_W-1:0] MY_X = 7'd5;
  localparam logic [`MCB_Y_W-1:0] MY_Y = 7'd3;

  logic                        clk_i;
  logic                        rst_i;
  bp_msg_s                     io_cmd_i;
  logic                        io_cmd_v_i;
  logic                        io_cmd_ready_o;
  bp_msg_s                     io_resp_o;
  logic                        io_resp_v_o;
  logic                        io_resp_yumi_i;
  mc_packet_s                  net_out_o;
  logic                        net_out_v_o;
  logic                        net_ready_i;
  mc_return_s                  net_ret_i;
  logic                        net_ret_v_i;
  mc_in_req_s                  net_in_i;
  logic                        net_in_v_i;
  logic                        net_in_yumi_o;
  bp_msg_s                     io_cmd_o;
  logic                        io_cmd_v_o;
  logic                        io_cmd_yumi_i;
  bp_msg_s                     io_resp_i;
  logic                        io_resp_v_i;
  logic [`MCB_DATA_W-1:0]      net_returning_o;
  logic                        net_returning_v_o;
  logic [`MCB_X_W-1:0]         my_x_i;
  logic [`MCB_Y_W-1:0]         my_y_i;
  integer                      seed;
  logic [`MCB_SLOT_ID_W-1:0]   next_slot;

  mc_bridge UUT
    (.clk_i(clk_i), .rst_i(rst_i)
    ,.io_cmd_i(io_cmd_i), .io_cmd_v_i(io_cmd_v_i), .io_cmd_ready_o(io_cmd_ready_o)
    ,.io_resp_o(io_resp_o), .io_resp_v_o(io_resp_v_o), .io_resp_yumi_i(io_resp_yumi_i)
    ,.net_out_o(net_out_o), .net_out_v_o(net_out_v_o), .net_ready_i(net_ready_i)
    ,.net_ret_i(net_ret_i), .net_ret_v_i(net_ret_v_i)
    ,.net_in_i(net_in_i), .net_in_v_i(net_in_v_i), .net_in_yumi_o(net_in_yumi_o)
    ,.io_cmd_o(io_cmd_o), .io_cmd_v_o(io_cmd_v_o), .io_cmd_yumi_i(io_cmd_yumi_i)
    ,.io_resp_i(io_resp_i), .io_resp_v_i(io_resp_v_i)
    ,.net_returning_o(net_returning_o), .net_returning_v_o(net_returning_v_o)
    ,.my_x_i(my_x_i), .my_y_i(my_y_i)
    );

  bind mc_bridge mc_bridge_props props
    (.clk_i(clk_i), .rst_i(rst_i)
    ,.io_resp_o(io_resp_o), .io_resp_v_o(io_resp_v_o), .io_resp_yumi_i(io_resp_yumi_i)
    ,.net_out_v_o(net_out_v_o), .net_ready_i(net_ready_i)
    ,.io_cmd_v_o(io_cmd_v_o), .net_in_v_i(net_in_v_i)
    );

  always #20 clk_i = ~clk_i;

  ////////////////////
  // checking
  ////////////////////

  task automatic check_eq(input logic [127:0] got, input logic [127:0] exp,
                          input string what);
    assert (got == exp)
    else
    begin
      $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      $display("Test failed");
      $fatal(1, "wrong value on %s", what);
    end
  endtask

  task automatic timed_out(input string what);
    $display("Test failed");
    $fatal(1, "timeout while waiting for %s", what);
  endtask

  ////////////////////
  // stimulus builders
  ////////////////////

  function automatic bp_header_s make_hdr(input msg_type_e t, input msg_size_e s,
                                          input logic [`MCB_PADDR_W-1:0] a);
    bp_header_s h;
    h.msg_type = t;
    h.size     = s;
    h.addr     = a;
    h.lce_id   = 4'd1;
    return h;
  endfunction

  // prefix 11 with y above x above the 18 bit epa
  function automatic logic [`MCB_PADDR_W-1:0] tile_addr(input logic [6:0] x,
    input logic [6:0] y, input logic [17:0] epa, input logic [1:0] low);
    logic [`MCB_PADDR_W-1:0] a;
    a        = '0;
    a[39:38] = 2'b11;
    a[33:27] = y;
    a[26:20] = x;
    a[19:2]  = epa;
    a[1:0]   = low;
    return a;
  endfunction

  // prefix 10 leaves only pod bit 37 below it
  function automatic logic [`MCB_PADDR_W-1:0] vcache_addr(input logic [6:0] x,
    input logic pod, input logic [27:0] epa);
    logic [`MCB_PADDR_W-1:0] a;
    a        = '0;
    a[39:38] = 2'b10;
    a[37]    = pod;
    a[36:30] = x;
    a[29:2]  = epa;
    return a;
  endfunction

  function automatic logic [`MCB_PADDR_W-1:0] host_addr(input logic [27:0] epa,
    input logic [1:0] low);
    logic [`MCB_PADDR_W-1:0] a;
    a       = '0;
    a[29:2] = epa;
    a[1:0]  = low;
    return a;
  endfunction

  ////////////////////
  // bus handling
  ////////////////////

  task automatic send_cmd(input bp_header_s hdr, input logic [31:0] data);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!io_cmd_ready_o && n < WAIT_LIMIT)
    begin
      @(negedge clk_i);
      n++;
    end
    if (!io_cmd_ready_o)
      timed_out("io_cmd_ready_o");
    @(posedge clk_i);
    io_cmd_i.header <= hdr;
    io_cmd_i.data   <= data;
    io_cmd_v_i      <= 1'b1;
    @(posedge clk_i);
    io_cmd_v_i <= 1'b0;
  endtask

  // slots are handed out in circular order
  task automatic get_packet(output mc_packet_s pkt);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!net_out_v_o && n < WAIT_LIMIT)
    begin
      @(negedge clk_i);
      n++;
    end
    if (!net_out_v_o)
      timed_out("net_out_v_o");
    pkt = net_out_o;
    check_eq(pkt.reg_id, next_slot, "packet reg_id");
    check_eq(pkt.src_x, MY_X, "packet src_x");
    check_eq(pkt.src_y, MY_Y, "packet src_y");
    next_slot = next_slot + 1'b1;
  endtask

  task automatic issue(input bp_header_s hdr, input logic [31:0] data,
                       output mc_packet_s pkt);
    send_cmd(hdr, data);
    get_packet(pkt);
  endtask

  task automatic send_return(input logic [4:0] reg_id, input logic [31:0] data);
    @(posedge clk_i);
    net_ret_i.reg_id <= reg_id;
    net_ret_i.data   <= data;
    net_ret_v_i      <= 1'b1;
    @(posedge clk_i);
    net_ret_v_i <= 1'b0;
  endtask

  task automatic wait_resp_valid();
    int n;
    n = 0;
    @(negedge clk_i);
    while (!io_resp_v_o && n < WAIT_LIMIT)
    begin
      @(negedge clk_i);
      n++;
    end
    if (!io_resp_v_o)
      timed_out("io_resp_v_o");
  endtask

  task automatic check_resp(input bp_header_s hdr, input logic [31:0] data);
    bp_msg_s r;
    wait_resp_valid();
    r = io_resp_o;
    check_eq(r.header, hdr, "response header");
    check_eq(r.data, data, "response data");
    @(posedge clk_i);
    io_resp_yumi_i <= 1'b1;
    @(posedge clk_i);
    io_resp_yumi_i <= 1'b0;
  endtask

  task automatic finish_load(input logic [4:0] reg_id, input bp_header_s hdr);
    logic [31:0] d;
    d = $random(seed);
    send_return(reg_id, d);
    check_resp(hdr, d);
  endtask

  ////////////////////
  // directed tests
  ////////////////////

  task automatic test_tile_load();
    bp_header_s hdr;
    mc_packet_s pkt;
    hdr = make_hdr(e_uc_rd, e_size_2, tile_addr(7'd3, 7'd9, 18'h2_1234, 2'd2));
    issue(hdr, 32'h0, pkt);
    check_eq(pkt.op, e_remote_load, "tile load op");
    check_eq(pkt.dst_x, 7'd3, "tile dst_x");
    check_eq(pkt.dst_y, 7'd9, "tile dst_y");
    check_eq(pkt.addr, 28'h002_1234, "tile epa");
    check_eq(pkt.payload.load.info.is_byte, 1'b0, "tile load is_byte");
    check_eq(pkt.payload.load.info.is_hex, 1'b1, "tile load is_hex");
    check_eq(pkt.payload.load.info.part_sel, 2'd2, "tile load part_sel");
    finish_load(pkt.reg_id, hdr);
  endtask

  task automatic test_sub_word_store();
    bp_header_s hdr;
    mc_packet_s pkt;
    logic [31:0] d;
    // byte into lane 3
    hdr = make_hdr(e_uc_wr, e_size_1, tile_addr(7'd1, 7'd2, 18'h0_0040, 2'd3));
    issue(hdr, 32'h0000_00a5, pkt);
    check_eq(pkt.op, e_remote_store, "byte store op");
    check_eq(pkt.mask, 4'h8, "byte store mask");
    check_eq(pkt.payload.data, 32'ha500_0000, "byte store data");
    d = $random(seed);
    send_return(pkt.reg_id, d);
    check_resp(hdr, 32'h0);
    // half word into the upper lanes
    hdr = make_hdr(e_uc_wr, e_size_2, tile_addr(7'd1, 7'd2, 18'h0_0041, 2'd2));
    issue(hdr, 32'h0000_beef, pkt);
    check_eq(pkt.mask, 4'hc, "half store mask");
    check_eq(pkt.payload.data, 32'hbeef_0000, "half store data");
    d = $random(seed);
    send_return(pkt.reg_id, d);
    check_resp(hdr, 32'h0);
  endtask

  task automatic test_routing();
    bp_header_s hdr;
    mc_packet_s pkt;
    hdr = make_hdr(e_uc_rd, e_size_4, vcache_addr(7'd12, 1'b0, 28'h0ab_cdef));
    issue(hdr, 32'h0, pkt);
    check_eq(pkt.dst_x, 7'd12, "vcache pod 0 dst_x");
    check_eq(pkt.dst_y, 7'h0f, "vcache pod 0 dst_y");
    check_eq(pkt.addr, 28'h0ab_cdef, "vcache pod 0 epa");
    finish_load(pkt.reg_id, hdr);
    hdr = make_hdr(e_uc_rd, e_size_4, vcache_addr(7'd40, 1'b1, 28'h765_4321));
    issue(hdr, 32'h0, pkt);
    check_eq(pkt.dst_x, 7'd40, "vcache pod 1 dst_x");
    check_eq(pkt.dst_y, 7'h10, "vcache pod 1 dst_y");
    check_eq(pkt.addr, 28'h765_4321, "vcache pod 1 epa");
    finish_load(pkt.reg_id, hdr);
    // host sits one row above
    hdr = make_hdr(e_uc_rd, e_size_1, host_addr(28'h012_3456, 2'd1));
    issue(hdr, 32'h0, pkt);
    check_eq(pkt.dst_x, 7'd0, "host dst_x");
    check_eq(pkt.dst_y, MY_Y - 7'd1, "host dst_y");
    check_eq(pkt.addr, 28'h012_3456, "host epa");
    check_eq(pkt.payload.load.info.is_byte, 1'b1, "host load is_byte");
    check_eq(pkt.payload.load.info.part_sel, 2'd1, "host load part_sel");
    finish_load(pkt.reg_id, hdr);
  endtask

  task automatic test_out_of_order();
    bp_header_s hdr [3];
    logic [4:0] slot [3];
    logic [31:0] d [3];
    mc_packet_s pkt;
    for (int i = 0; i < 3; i++)
    begin
      hdr[i] = make_hdr(e_uc_rd, e_size_4, tile_addr(7'(i + 1), 7'd4, 18'(16 * i), 2'd0));
      issue(hdr[i], 32'h0, pkt);
      slot[i] = pkt.reg_id;
      d[i] = $random(seed);
    end
    send_return(slot[2], d[2]);
    send_return(slot[1], d[1]);
    // oldest still outstanding
    repeat (3)
    begin
      @(negedge clk_i);
      check_eq(io_resp_v_o, 1'b0, "io_resp_v_o before oldest return");
    end
    send_return(slot[0], d[0]);
    for (int i = 0; i < 3; i++)
      check_resp(hdr[i], d[i]);
  endtask

  task automatic test_backpressure();
    bp_header_s hdr [5];
    logic [4:0] slot [5];
    logic [31:0] d [5];
    mc_packet_s pkt;
    bp_msg_s held;
    for (int i = 0; i < 5; i++)
    begin
      hdr[i] = make_hdr(e_uc_rd, e_size_4, tile_addr(7'd6, 7'd7, 18'(4 * i), 2'd0));
      d[i] = $random(seed);
    end
    @(posedge clk_i);
    net_ready_i <= 1'b0;
    send_cmd(hdr[0], 32'h0);
    repeat (5)
    begin
      @(negedge clk_i);
      check_eq(net_out_v_o, 1'b0, "net_out_v_o with net_ready_i low");
    end
    @(posedge clk_i);
    net_ready_i <= 1'b1;
    get_packet(pkt);
    slot[0] = pkt.reg_id;
    for (int i = 1; i < 4; i++)
    begin
      issue(hdr[i], 32'h0, pkt);
      slot[i] = pkt.reg_id;
    end
    // fifth command waits in the FIFO with every slot busy
    send_cmd(hdr[4], 32'h0);
    repeat (6)
    begin
      @(negedge clk_i);
      check_eq(net_out_v_o, 1'b0, "net_out_v_o with all slots busy");
    end
    send_return(slot[0], d[0]);
    wait_resp_valid();
    held = io_resp_o;
    repeat (4)
    begin
      @(negedge clk_i);
      check_eq(io_resp_v_o, 1'b1, "io_resp_v_o without yumi");
      check_eq(io_resp_o, held, "io_resp_o without yumi");
      check_eq(net_out_v_o, 1'b0, "net_out_v_o before the oldest response is consumed");
    end
    check_resp(hdr[0], d[0]);
    get_packet(pkt);
    slot[4] = pkt.reg_id;
    for (int i = 1; i < 5; i++)
    begin
      send_return(slot[i], d[i]);
      check_resp(hdr[i], d[i]);
    end
  endtask

  task automatic test_inbound();
    mc_in_req_s req;
    bp_msg_s ans;
    logic [31:0] d;
    d = $random(seed);
    req       = '0;
    req.we    = 1'b1;
    req.epa   = 28'({4'd1, 12'h0ac});
    req.data  = d;
    req.src_x = 7'd2;
    @(posedge clk_i);
    net_in_i      <= req;
    net_in_v_i    <= 1'b1;
    io_cmd_yumi_i <= 1'b1;
    @(negedge clk_i);
    check_eq(io_cmd_v_o, 1'b1, "io_cmd_v_o");
    check_eq(net_in_yumi_o, 1'b1, "net_in_yumi_o");
    check_eq(io_cmd_o.header.msg_type, e_uc_wr, "clint write msg_type");
    check_eq(io_cmd_o.header.addr, `MCB_CLINT_BASE + 40'h0ac, "clint write addr");
    check_eq(io_cmd_o.header.size, e_size_4, "clint write size");
    check_eq(io_cmd_o.data, d, "clint write data");
    // read of the config device
    req.we  = 1'b0;
    req.epa = 28'({4'd0, 12'h010});
    @(posedge clk_i);
    net_in_i      <= req;
    io_cmd_yumi_i <= 1'b0;
    @(negedge clk_i);
    check_eq(net_in_yumi_o, 1'b0, "net_in_yumi_o without yumi");
    check_eq(io_cmd_o.header.msg_type, e_uc_rd, "cfg read msg_type");
    check_eq(io_cmd_o.header.addr, `MCB_CFG_BASE + 40'h010, "cfg read addr");
    ans             = '0;
    ans.header.size = e_size_2;
    ans.data        = 32'hdead_beef;
    @(posedge clk_i);
    net_in_v_i  <= 1'b0;
    io_resp_i   <= ans;
    io_resp_v_i <= 1'b1;
    @(negedge clk_i);
    check_eq(io_cmd_v_o, 1'b0, "io_cmd_v_o after request");
    check_eq(net_returning_v_o, 1'b1, "net_returning_v_o");
    check_eq(net_returning_o, 32'h0000_beef, "net_returning_o for size 2");
    @(posedge clk_i);
    io_resp_v_i <= 1'b0;
  endtask

  initial
  begin
    seed           = 63;
    clk_i          = 1'b0;
    rst_i          = 1'b1;
    io_cmd_i       = '0;
    io_cmd_v_i     = 1'b0;
    io_resp_yumi_i = 1'b0;
    net_ready_i    = 1'b1;
    net_ret_i      = '0;
    net_ret_v_i    = 1'b0;
    net_in_i       = '0;
    net_in_v_i     = 1'b0;
    io_cmd_yumi_i  = 1'b0;
    io_resp_i      = '0;
    io_resp_v_i    = 1'b0;
    my_x_i         = MY_X;
    my_y_i         = MY_Y;
    next_slot      = '0;
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    check_eq(io_resp_v_o, 1'b0, "io_resp_v_o after reset");
    check_eq(net_out_v_o, 1'b0, "net_out_v_o after reset");
    check_eq(io_cmd_ready_o, 1'b1, "io_cmd_ready_o after reset");
    test_tile_load();
    test_sub_word_store();
    test_routing();
    test_out_of_order();
    test_backpressure();
    test_inbound();
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/mc_bridge_props.sv ====
`default_nettype none

module mc_bridge_props
  ( input  wire logic                    clk_i
  , input  wire logic                    rst_i
  , input  wire mc_bridge_pkg::bp_msg_s  io_resp_o
  , input  wire logic                    io_resp_v_o
  , input  wire logic                    io_resp_yumi_i
  , input  wire logic                    net_out_v_o
  , input  wire logic                    net_ready_i
  , input  wire logic                    io_cmd_v_o
  , input  wire logic                    net_in_v_i
  );

  timeunit 1ns;
  timeprecision 1ps;

  import mc_bridge_pkg::*;

  // packets only leave toward a ready network
  a_out_needs_ready: assert property (@(posedge clk_i) disable iff (rst_i)
    net_out_v_o |-> net_ready_i)
    else $error("net_out_v_o high while net_ready_i is low");

  a_inbound_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    io_cmd_v_o == net_in_v_i)
    else $error("io_cmd_v_o does not follow net_in_v_i");

  // a waiting response must not change
  a_resp_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    (io_resp_v_o && !io_resp_yumi_i) |=> $stable(io_resp_o))
    else $error("io_resp_o changed while waiting for yumi");

  // first reset edge clears the state
  a_quiet_in_reset: assert property (@(posedge clk_i)
    (rst_i && $past(rst_i)) |-> (!io_resp_v_o && !net_out_v_o))
    else $error("valid output high during reset");

endmodule

`default_nettype wire

// ==== hw/mc_bridge.sv ====
`include "mc_bridge_settings.svh"

`default_nettype none

module mc_bridge
  ( input  wire logic                       clk_i
  , input  wire logic                       rst_i

  , input  wire mc_bridge_pkg::bp_msg_s     io_cmd_i
  , input  wire logic                       io_cmd_v_i
  , output logic                            io_cmd_ready_o

  , output mc_bridge_pkg::bp_msg_s          io_resp_o
  , output logic                            io_resp_v_o
  , input  wire logic                       io_resp_yumi_i

  , output mc_bridge_pkg::mc_packet_s       net_out_o
  , output logic                            net_out_v_o
  , input  wire logic                       net_ready_i

  , input  wire mc_bridge_pkg::mc_return_s  net_ret_i
  , input  wire logic                       net_ret_v_i

  , input  wire mc_bridge_pkg::mc_in_req_s  net_in_i
  , input  wire logic                       net_in_v_i
  , output logic                            net_in_yumi_o

  , output mc_bridge_pkg::bp_msg_s          io_cmd_o
  , output logic                            io_cmd_v_o
  , input  wire logic                       io_cmd_yumi_i

  , input  wire mc_bridge_pkg::bp_msg_s     io_resp_i
  , input  wire logic                       io_resp_v_i

  , output logic [`MCB_DATA_W-1:0]          net_returning_o
  , output logic                            net_returning_v_o

  , input  wire logic [`MCB_X_W-1:0]        my_x_i
  , input  wire logic [`MCB_Y_W-1:0]        my_y_i
  );

  import mc_bridge_pkg::*;

  bp_msg_s                 fifo_cmd;
  logic                    fifo_v;
  logic                    fifo_yumi;
  logic [`MCB_SLOTS-1:0]   slot_busy;
  logic [`MCB_SLOTS-1:0]   slot_done;
  logic [`MCB_SLOTS-1:0]   slot_alloc;
  logic [`MCB_SLOTS-1:0]   slot_release;
  bp_header_s              alloc_hdr;
  bp_header_s              slot_hdr [`MCB_SLOTS];
  logic [`MCB_DATA_W-1:0]  slot_data [`MCB_SLOTS];

  ////////////////////
  // outbound commands
  ////////////////////

  cmd_fifo cmd_buf
    (.clk_i(clk_i), .rst_i(rst_i)
    ,.data_i(io_cmd_i), .v_i(io_cmd_v_i), .ready_o(io_cmd_ready_o)
    ,.data_o(fifo_cmd), .v_o(fifo_v), .yumi_i(fifo_yumi)
    );

  request_issue issuer
    (.clk_i(clk_i), .rst_i(rst_i)
    ,.cmd_i(fifo_cmd), .cmd_v_i(fifo_v), .cmd_yumi_o(fifo_yumi)
    ,.slot_busy_i(slot_busy), .net_ready_i(net_ready_i)
    ,.my_x_i(my_x_i), .my_y_i(my_y_i)
    ,.alloc_o(slot_alloc), .alloc_hdr_o(alloc_hdr)
    ,.net_out_o(net_out_o), .net_out_v_o(net_out_v_o)
    );

  // one slot per outstanding transaction
  for (genvar i = 0; i < `MCB_SLOTS; i++)
  begin : g_slot
    trans_slot #(.SLOT_ID(i)) slot
      (.clk_i(clk_i), .rst_i(rst_i)
      ,.alloc_i(slot_alloc[i]), .hdr_i(alloc_hdr)
      ,.ret_i(net_ret_i), .ret_v_i(net_ret_v_i)
      ,.release_i(slot_release[i])
      ,.busy_o(slot_busy[i]), .done_o(slot_done[i])
      ,.hdr_o(slot_hdr[i]), .data_o(slot_data[i])
      );
  end

  resp_collector collector
    (.clk_i(clk_i), .rst_i(rst_i)
    ,.slot_done_i(slot_done), .slot_hdr_i(slot_hdr), .slot_data_i(slot_data)
    ,.slot_release_o(slot_release)
    ,.io_resp_o(io_resp_o), .io_resp_v_o(io_resp_v_o), .io_resp_yumi_i(io_resp_yumi_i)
    );

  ////////////////////
  // inbound requests
  ////////////////////

  inbound_xlate inbound
    (.net_in_i(net_in_i), .net_in_v_i(net_in_v_i), .net_in_yumi_o(net_in_yumi_o)
    ,.io_cmd_o(io_cmd_o), .io_cmd_v_o(io_cmd_v_o), .io_cmd_yumi_i(io_cmd_yumi_i)
    ,.io_resp_i(io_resp_i), .io_resp_v_i(io_resp_v_i)
    ,.net_returning_o(net_returning_o), .net_returning_v_o(net_returning_v_o)
    );

endmodule

`default_nettype wire

// ==== hw/inbound_xlate.sv ====
`include "mc_bridge_settings.svh"

`default_nettype none

module inbound_xlate
  ( input  wire mc_bridge_pkg::mc_in_req_s  net_in_i
  , input  wire logic                       net_in_v_i
  , output logic                            net_in_yumi_o
  , output mc_bridge_pkg::bp_msg_s          io_cmd_o
  , output logic                            io_cmd_v_o
  , input  wire logic                       io_cmd_yumi_i
  , input  wire mc_bridge_pkg::bp_msg_s     io_resp_i
  , input  wire logic                       io_resp_v_i
  , output logic [`MCB_DATA_W-1:0]          net_returning_o
  , output logic                            net_returning_v_o
  );

  import mc_bridge_pkg::*;

  bp_epa_s epa;

  assign epa = net_in_i.epa[0 +: $bits(bp_epa_s)];

  ////////////////////
  // request to command
  ////////////////////

  always_comb
  begin
    io_cmd_o                 = '0;
    io_cmd_o.header.msg_type = net_in_i.we ? e_uc_wr : e_uc_rd;
    // only full words reach the config space
    io_cmd_o.header.size     = e_size_4;
    io_cmd_o.header.lce_id   = `MCB_LCE_ID_W'(`MCB_IO_LCE_ID);
    if (epa.dev == 4'd1)
      io_cmd_o.header.addr = `MCB_CLINT_BASE + epa.addr;
    else
      io_cmd_o.header.addr = `MCB_CFG_BASE + epa.addr;
    io_cmd_o.data = net_in_i.data;
  end

  assign io_cmd_v_o    = net_in_v_i;
  assign net_in_yumi_o = io_cmd_yumi_i;

  ////////////////////
  // answer to returning data
  ////////////////////

  always_comb
  begin
    case (io_resp_i.header.size)
      e_size_4: net_returning_o = io_resp_i.data;
      e_size_2: net_returning_o = `MCB_DATA_W'(io_resp_i.data[15:0]);
      default:  net_returning_o = `MCB_DATA_W'(io_resp_i.data[7:0]);
    endcase
  end

  assign net_returning_v_o = io_resp_v_i;

endmodule

`default_nettype wire

// ==== hw/resp_collector.sv ====
`include "mc_bridge_settings.svh"

`default_nettype none

module resp_collector
  ( input  wire logic                       clk_i
  , input  wire logic                       rst_i
  , input  wire logic [`MCB_SLOTS-1:0]      slot_done_i
  , input  wire mc_bridge_pkg::bp_header_s  slot_hdr_i [`MCB_SLOTS]
  , input  wire logic [`MCB_DATA_W-1:0]     slot_data_i [`MCB_SLOTS]
  , output logic [`MCB_SLOTS-1:0]           slot_release_o
  , output mc_bridge_pkg::bp_msg_s          io_resp_o
  , output logic                            io_resp_v_o
  , input  wire logic                       io_resp_yumi_i
  );

  import mc_bridge_pkg::*;

  logic [`MCB_SLOT_ID_W-1:0]  rel_ptr_r;
  bp_header_s                 head_hdr;
  logic                       fire;

  // oldest slot sits at the release pointer
  assign head_hdr    = slot_hdr_i[rel_ptr_r];
  assign io_resp_v_o = slot_done_i[rel_ptr_r];

  ////////////////////
  // response build
  ////////////////////

  always_comb
  begin
    io_resp_o.header = head_hdr;
    // writes carry no data back
    if (head_hdr.msg_type == e_uc_wr)
      io_resp_o.data = '0;
    else
      io_resp_o.data = slot_data_i[rel_ptr_r];
  end

  assign fire           = io_resp_v_o & io_resp_yumi_i;
  assign slot_release_o = fire ? (`MCB_SLOTS'(1) << rel_ptr_r) : '0;

  // pointer follows issue order
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      rel_ptr_r <= '0;
    else if (fire)
      rel_ptr_r <= rel_ptr_r + 1'b1;
  end

endmodule

`default_nettype wire

// ==== hw/trans_slot.sv ====
`include "mc_bridge_settings.svh"

`default_nettype none

module trans_slot
  #( parameter int SLOT_ID = 0
   )
  ( input  wire logic                       clk_i
  , input  wire logic                       rst_i
  , input  wire logic                       alloc_i
  , input  wire mc_bridge_pkg::bp_header_s  hdr_i
  , input  wire mc_bridge_pkg::mc_return_s  ret_i
  , input  wire logic                       ret_v_i
  , input  wire logic                       release_i
  , output logic                            busy_o
  , output logic                            done_o
  , output mc_bridge_pkg::bp_header_s       hdr_o
  , output logic [`MCB_DATA_W-1:0]          data_o
  );

  import mc_bridge_pkg::*;

  localparam logic [`MCB_REG_ID_W-1:0] MY_ID = `MCB_REG_ID_W'(SLOT_ID);

  logic                    busy_r;
  logic                    done_r;
  bp_header_s              hdr_r;
  logic [`MCB_DATA_W-1:0]  data_r;
  logic                    hit;

  // return addressed to this slot
  assign hit = ret_v_i & busy_r & (ret_i.reg_id == MY_ID);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      busy_r <= 1'b0;
      done_r <= 1'b0;
    end
    else if (alloc_i)
    begin
      busy_r <= 1'b1;
      done_r <= 1'b0;
    end
    else if (release_i)
    begin
      busy_r <= 1'b0;
      done_r <= 1'b0;
    end
    else if (hit)
      done_r <= 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (alloc_i)
      hdr_r <= hdr_i;
    if (hit)
      data_r <= ret_i.data;
  end

  assign busy_o = busy_r;
  assign done_o = done_r;
  assign hdr_o  = hdr_r;
  assign data_o = data_r;

endmodule

`default_nettype wire

// ==== hw/request_issue.sv ====
`include "mc_bridge_settings.svh"

`default_nettype none

module request_issue
  ( input  wire logic                    clk_i
  , input  wire logic                    rst_i
  , input  wire mc_bridge_pkg::bp_msg_s  cmd_i
  , input  wire logic                    cmd_v_i
  , output logic                         cmd_yumi_o
  , input  wire logic [`MCB_SLOTS-1:0]   slot_busy_i
  , input  wire logic                    net_ready_i
  , input  wire logic [`MCB_X_W-1:0]     my_x_i
  , input  wire logic [`MCB_Y_W-1:0]     my_y_i
  , output logic [`MCB_SLOTS-1:0]        alloc_o
  , output mc_bridge_pkg::bp_header_s    alloc_hdr_o
  , output mc_bridge_pkg::mc_packet_s    net_out_o
  , output logic                         net_out_v_o
  );

  import mc_bridge_pkg::*;

  // field positions inside the processor address
  localparam int TILE_X_LSB = 2 + `MCB_TILE_EPA_W;
  localparam int TILE_Y_LSB = TILE_X_LSB + `MCB_X_W;
  localparam int VC_X_LSB   = 2 + `MCB_ADDR_W;
  localparam int VC_POD_LSB = VC_X_LSB + `MCB_X_W;
  localparam int PREFIX_LSB = `MCB_PADDR_W - 2;

  logic [`MCB_SLOT_ID_W-1:0]  alloc_ptr_r;
  logic [`MCB_PADDR_W-1:0]    addr;
  logic [1:0]                 low_bits;
  logic [1:0]                 prefix;
  logic [`MCB_POD_Y_W-1:0]    vc_pod;
  logic [`MCB_Y_SUB_W-1:0]    vc_y_sub;
  logic [`MCB_MASK_W-1:0]     store_mask;
  load_info_s                 load_info;
  mc_packet_s                 pkt;
  logic                       fire;

  assign addr     = cmd_i.header.addr;
  assign low_bits = addr[1:0];
  assign prefix   = addr[PREFIX_LSB +: 2];

  ////////////////////
  // address decode
  ////////////////////

  // pod bits that overlap the prefix read as zero
  always_comb
  begin
    vc_pod = addr[VC_POD_LSB +: `MCB_POD_Y_W];
    for (int b = 0; b < `MCB_POD_Y_W; b++)
    begin
      if (VC_POD_LSB + b >= PREFIX_LSB)
        vc_pod[b] = 1'b0;
    end
    vc_y_sub = (vc_pod == '0) ? '1 : '0;
  end

  always_comb
  begin
    case (cmd_i.header.size)
      e_size_1: store_mask = 4'h1 << low_bits;
      e_size_2: store_mask = 4'h3 << low_bits;
      default:  store_mask = 4'hf << low_bits;
    endcase
  end

  assign load_info = '{is_byte:  (cmd_i.header.size == e_size_1),
                       is_hex:   (cmd_i.header.size == e_size_2),
                       part_sel: low_bits};

  ////////////////////
  // packet build
  ////////////////////

  always_comb
  begin
    pkt        = '0;
    pkt.src_x  = my_x_i;
    pkt.src_y  = my_y_i;
    pkt.reg_id = `MCB_REG_ID_W'(alloc_ptr_r);

    if (prefix == `MCB_TILE_PREFIX)
    begin
      pkt.addr  = `MCB_ADDR_W'(addr[2 +: `MCB_TILE_EPA_W]);
      pkt.dst_x = addr[TILE_X_LSB +: `MCB_X_W];
      pkt.dst_y = addr[TILE_Y_LSB +: `MCB_Y_W];
    end
    else if (prefix == `MCB_VCACHE_PREFIX)
    begin
      pkt.addr  = addr[2 +: `MCB_ADDR_W];
      pkt.dst_x = addr[VC_X_LSB +: `MCB_X_W];
      pkt.dst_y = {vc_pod, vc_y_sub};
    end
    else
    begin
      // host sits one row above the bridge
      pkt.addr  = addr[2 +: `MCB_ADDR_W];
      pkt.dst_x = '0;
      pkt.dst_y = my_y_i - 1'b1;
    end

    if (cmd_i.header.msg_type == e_uc_wr)
    begin
      pkt.op           = e_remote_store;
      pkt.mask         = store_mask;
      pkt.payload.data = cmd_i.data << {low_bits, 3'b000};
    end
    else
    begin
      pkt.op                = e_remote_load;
      pkt.payload.load.info = load_info;
    end
  end

  // issue only into a free slot with the network ready
  assign fire        = cmd_v_i & ~slot_busy_i[alloc_ptr_r] & net_ready_i;
  assign cmd_yumi_o  = fire;
  assign net_out_v_o = fire;
  assign net_out_o   = pkt;
  assign alloc_o     = fire ? (`MCB_SLOTS'(1) << alloc_ptr_r) : '0;
  assign alloc_hdr_o = cmd_i.header;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      alloc_ptr_r <= '0;
    else if (fire)
      alloc_ptr_r <= alloc_ptr_r + 1'b1;
  end

endmodule

`default_nettype wire

// ==== hw/cmd_fifo.sv ====
`include "mc_bridge_settings.svh"

`default_nettype none

module cmd_fifo
  ( input  wire logic                    clk_i
  , input  wire logic                    rst_i
  , input  wire mc_bridge_pkg::bp_msg_s  data_i
  , input  wire logic                    v_i
  , output logic                         ready_o
  , output mc_bridge_pkg::bp_msg_s       data_o
  , output logic                         v_o
  , input  wire logic                    yumi_i
  );

  import mc_bridge_pkg::*;

  localparam int DEPTH = `MCB_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);
  localparam logic [PTR_W:0] FULL = (PTR_W + 1)'(DEPTH);

  bp_msg_s           mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_r;
  logic [PTR_W-1:0]  rd_ptr_r;
  logic [PTR_W:0]    count_r;
  logic              push;
  logic              pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == LAST)
      nxt = '0;
    else
      nxt = ptr + 1'b1;
    return nxt;
  endfunction

  assign ready_o = (count_r != FULL);
  assign v_o     = (count_r != '0);
  assign data_o  = mem[rd_ptr_r];
  assign push    = v_i & ready_o;
  assign pop     = yumi_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_r <= next_ptr(wr_ptr_r);
      if (pop)
        rd_ptr_r <= next_ptr(rd_ptr_r);
      if (push & ~pop)
        count_r <= count_r + 1'b1;
      else if (pop & ~push)
        count_r <= count_r - 1'b1;
    end
  end

  // storage
  always_ff @(posedge clk_i)
  begin
    if (push)
      mem[wr_ptr_r] <= data_i;
  end

endmodule

`default_nettype wire

// ==== hw/mc_bridge_pkg.sv ====
`include "mc_bridge_settings.svh"

`default_nettype none

package mc_bridge_pkg;

  ////////////////////
  // processor side
  ////////////////////

  typedef enum logic [1:0]
  {
    e_uc_rd = 2'd0,
    e_uc_wr = 2'd1
  } msg_type_e;

  typedef enum logic [1:0]
  {
    e_size_1 = 2'd0,
    e_size_2 = 2'd1,
    e_size_4 = 2'd2
  } msg_size_e;

  typedef struct packed
  {
    msg_type_e                 msg_type;
    msg_size_e                 size;
    logic [`MCB_PADDR_W-1:0]   addr;
    logic [`MCB_LCE_ID_W-1:0]  lce_id;
  } bp_header_s;

  typedef struct packed
  {
    bp_header_s               header;
    logic [`MCB_DATA_W-1:0]   data;
  } bp_msg_s;

  ////////////////////
  // network side
  ////////////////////

  typedef enum logic [1:0]
  {
    e_remote_load  = 2'd0,
    e_remote_store = 2'd1
  } mc_op_e;

  typedef struct packed
  {
    logic        is_byte;
    logic        is_hex;
    logic [1:0]  part_sel;
  } load_info_s;

  typedef struct packed
  {
    logic [`MCB_DATA_W-$bits(load_info_s)-1:0]  pad;
    load_info_s                                 info;
  } load_word_s;

  // store data or load info, chosen by op
  typedef union packed
  {
    logic [`MCB_DATA_W-1:0]  data;
    load_word_s              load;
  } mc_payload_u;

  typedef struct packed
  {
    logic [`MCB_ADDR_W-1:0]    addr;
    mc_op_e                    op;
    logic [`MCB_MASK_W-1:0]    mask;
    logic [`MCB_REG_ID_W-1:0]  reg_id;
    mc_payload_u               payload;
    logic [`MCB_X_W-1:0]       src_x;
    logic [`MCB_Y_W-1:0]       src_y;
    logic [`MCB_X_W-1:0]       dst_x;
    logic [`MCB_Y_W-1:0]       dst_y;
  } mc_packet_s;

  typedef struct packed
  {
    logic [`MCB_REG_ID_W-1:0]  reg_id;
    logic [`MCB_DATA_W-1:0]    data;
  } mc_return_s;

  typedef struct packed
  {
    logic                      we;
    logic [`MCB_ADDR_W-1:0]    epa;
    logic [`MCB_DATA_W-1:0]    data;
    logic [`MCB_X_W-1:0]       src_x;
    logic [`MCB_Y_W-1:0]       src_y;
  } mc_in_req_s;

  // dev 0 is cfg, dev 1 is clint
  typedef struct packed
  {
    logic [3:0]   dev;
    logic [11:0]  addr;
  } bp_epa_s;

endpackage

`default_nettype wire

// ==== hw/mc_bridge_settings.svh ====
`ifndef MC_BRIDGE_SETTINGS_SVH
`define MC_BRIDGE_SETTINGS_SVH

// processor side
`define MCB_PADDR_W        40
`define MCB_LCE_ID_W       4
`define MCB_IO_LCE_ID      2

// network side
`define MCB_DATA_W         32
`define MCB_MASK_W         (`MCB_DATA_W/8)
`define MCB_ADDR_W         28
`define MCB_X_W            7
`define MCB_Y_W            7
`define MCB_POD_Y_W        3
`define MCB_Y_SUB_W        4
`define MCB_TILE_EPA_W     18
`define MCB_REG_ID_W       5

// outstanding transactions and command buffering
`define MCB_SLOTS          4
`define MCB_SLOT_ID_W      2
`define MCB_FIFO_DEPTH     2

// address decode and inbound device bases
`define MCB_TILE_PREFIX    2'b11
`define MCB_VCACHE_PREFIX  2'b10
`define MCB_CFG_BASE       40'h20_0000
`define MCB_CLINT_BASE     40'h30_0000

`endif
